/* verilog/axi_chan_pkg.sv */
package axi_chan_pkg;

  // Field widths of the AXI channels
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [5:0]           atop_t;
  typedef logic [1:0]           resp_t;

  // B and R response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Atomic type, found in atop bits 5:4
  localparam logic [1:0] ATOP_NONE  = 2'b00;
  localparam logic [1:0] ATOP_STORE = 2'b01;
  localparam logic [1:0] ATOP_LOAD  = 2'b10;

  // Set for atomics that also return an R beat
  localparam int unsigned ATOP_R_RESP = 5;

endpackage

/* verilog/serializer_pkg.sv */
package serializer_pkg;

  // Isolation of atomics in the serializer
  //   ATOP_IDLE     normal traffic, IDs are queued
  //   ATOP_DRAIN    atomic seen, waiting for all outstanding responses
  //   ATOP_EXECUTE  atomic forwarded, waiting for its own responses
  typedef enum logic [1:0] {
    ATOP_IDLE    = 2'b00,
    ATOP_DRAIN   = 2'b01,
    ATOP_EXECUTE = 2'b10
  } atop_state_e;

endpackage

/* verilog/id_fifo.sv */
`timescale 1ns/1ns

module id_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              push_i,
  input  logic              pop_i,
  input  axi_chan_pkg::id_t data_i,
  output axi_chan_pkg::id_t data_o,
  output logic              full_o,
  output logic              empty_o
);
  import axi_chan_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [PtrWidth-1:0] LastIdx  = PtrWidth'(Depth - 1);
  localparam logic [PtrWidth:0]   FullCount = (PtrWidth + 1)'(Depth);

  id_t                 entries_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                do_push, do_pop;

  assign full_o  = (count_q == FullCount);
  assign empty_o = (count_q == '0);

  // Requests that cannot be served are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Oldest entry, a fresh push only shows up after the clock edge
  assign data_o = entries_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LastIdx) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LastIdx) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + do_push - do_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      entries_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* verilog/axi_serializer.sv */
`timescale 1ns/1ns

module axi_serializer #(
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Upstream side
  input  logic                s_aw_valid_i,
  output logic                s_aw_ready_o,
  input  axi_chan_pkg::id_t   s_aw_id_i,
  input  axi_chan_pkg::atop_t s_aw_atop_i,
  input  logic                s_w_valid_i,
  output logic                s_w_ready_o,
  output logic                s_b_valid_o,
  input  logic                s_b_ready_i,
  output axi_chan_pkg::id_t   s_b_id_o,
  input  logic                s_ar_valid_i,
  output logic                s_ar_ready_o,
  input  axi_chan_pkg::id_t   s_ar_id_i,
  output logic                s_r_valid_o,
  input  logic                s_r_ready_i,
  input  logic                s_r_last_i_from_target,
  output axi_chan_pkg::id_t   s_r_id_o,
  // Downstream side
  output logic                m_aw_valid_o,
  input  logic                m_aw_ready_i,
  output axi_chan_pkg::id_t   m_aw_id_o,
  output logic                m_w_valid_o,
  input  logic                m_w_ready_i,
  input  logic                m_b_valid_i,
  output logic                m_b_ready_o,
  output logic                m_ar_valid_o,
  input  logic                m_ar_ready_i,
  output axi_chan_pkg::id_t   m_ar_id_o,
  input  logic                m_r_valid_i,
  output logic                m_r_ready_o,
  input  logic                m_r_last_i
);
  import axi_chan_pkg::*;
  import serializer_pkg::*;

  atop_state_e state_q, state_d;
  logic        rd_push, rd_pop, rd_full, rd_empty;
  logic        wr_push, wr_pop, wr_full, wr_empty;
  logic        aw_is_atop;
  id_t         rd_push_id;

  assign aw_is_atop = (s_aw_atop_i[5:4] != ATOP_NONE);

  // Everything leaves with ID zero
  assign m_aw_id_o = '0;
  assign m_ar_id_o = '0;

  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  // A response only passes while its ID is queued
  assign s_b_valid_o = m_b_valid_i & ~wr_empty;
  assign m_b_ready_o = s_b_ready_i & ~wr_empty;
  assign wr_pop      = s_b_valid_o & s_b_ready_i;

  assign s_r_valid_o = m_r_valid_i & ~rd_empty;
  assign m_r_ready_o = s_r_ready_i & ~rd_empty;
  // Both last flags belong to the same beat
  assign rd_pop = s_r_valid_o & s_r_ready_i & s_r_last_i_from_target & m_r_last_i;

  always_comb begin
    state_d      = state_q;
    m_aw_valid_o = 1'b0;
    s_aw_ready_o = 1'b0;
    m_ar_valid_o = 1'b0;
    s_ar_ready_o = 1'b0;
    wr_push      = 1'b0;
    rd_push      = 1'b0;
    rd_push_id   = s_ar_id_i;

    unique case (state_q)
      ATOP_IDLE: begin
        m_ar_valid_o = s_ar_valid_i & ~rd_full;
        s_ar_ready_o = m_ar_ready_i & ~rd_full;
        rd_push      = m_ar_valid_o & m_ar_ready_i;
        if (s_aw_valid_i) begin
          if (!aw_is_atop) begin
            m_aw_valid_o = ~wr_full;
            s_aw_ready_o = m_aw_ready_i & ~wr_full;
            wr_push      = m_aw_valid_o & m_aw_ready_i;
          end else if (!m_ar_valid_o || m_ar_ready_i) begin
            // Hold the atomic, but let a pending AR finish first
            state_d = ATOP_DRAIN;
          end
        end
      end
      ATOP_DRAIN: begin
        if (wr_empty && rd_empty) begin
          m_aw_valid_o = s_aw_valid_i;
          s_aw_ready_o = m_aw_ready_i;
          wr_push      = s_aw_valid_i & m_aw_ready_i;
          // Atomics with an R beat also need their ID on the read side
          if (s_aw_atop_i[ATOP_R_RESP]) begin
            rd_push_id = s_aw_id_i;
            rd_push    = wr_push;
          end
          if (wr_push) begin
            state_d = ATOP_EXECUTE;
          end
        end
      end
      ATOP_EXECUTE: begin
        if (wr_empty && rd_empty) begin
          state_d = ATOP_IDLE;
        end
      end
      default: state_d = ATOP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ATOP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  id_fifo #(
    .Depth ( MaxReadTxns )
  ) read_ids (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .push_i  ( rd_push    ),
    .pop_i   ( rd_pop     ),
    .data_i  ( rd_push_id ),
    .data_o  ( s_r_id_o   ),
    .full_o  ( rd_full    ),
    .empty_o ( rd_empty   )
  );

  id_fifo #(
    .Depth ( MaxWriteTxns )
  ) write_ids (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .push_i  ( wr_push   ),
    .pop_i   ( wr_pop    ),
    .data_i  ( s_aw_id_i ),
    .data_o  ( s_b_id_o  ),
    .full_o  ( wr_full   ),
    .empty_o ( wr_empty  )
  );

endmodule

/* verilog/mem_target.sv */
`timescale 1ns/1ns

module mem_target (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_chan_pkg::addr_t aw_addr_i,
  input  axi_chan_pkg::atop_t aw_atop_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  axi_chan_pkg::data_t w_data_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axi_chan_pkg::resp_t b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  axi_chan_pkg::addr_t ar_addr_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_chan_pkg::data_t r_data_o,
  output axi_chan_pkg::resp_t r_resp_o,
  output logic                r_last_o
);
  import axi_chan_pkg::*;

  localparam int unsigned MemWords = 16;
  localparam int unsigned IdxWidth = $clog2(MemWords);

  data_t               mem_q [MemWords];
  logic                b_pending_q, r_pending_q;
  resp_t               b_resp_q, r_resp_q;
  data_t               r_data_q;
  logic                idle, wr_both, wr_accept, rd_accept;
  logic [IdxWidth-1:0] wr_idx, rd_idx;
  logic                wr_out_of_range, rd_out_of_range;
  logic                is_plain, is_add, wr_fail;
  data_t               old_word;

  // One transaction at a time, a write wins over a read
  assign idle    = ~b_pending_q & ~r_pending_q;
  assign wr_both = aw_valid_i & w_valid_i;

  assign aw_ready_o = idle & wr_both;
  assign w_ready_o  = idle & wr_both;
  assign ar_ready_o = idle & ~wr_both;
  assign wr_accept  = idle & wr_both;
  assign rd_accept  = ar_ready_o & ar_valid_i;

  // Word index from the byte address
  assign wr_idx          = aw_addr_i[IdxWidth+1:2];
  assign rd_idx          = ar_addr_i[IdxWidth+1:2];
  assign wr_out_of_range = (aw_addr_i >= AddrWidth'(MemWords * 4));
  assign rd_out_of_range = (ar_addr_i >= AddrWidth'(MemWords * 4));

  assign is_plain = (aw_atop_i[5:4] == ATOP_NONE);
  assign is_add   = (aw_atop_i[5:4] == ATOP_STORE) || (aw_atop_i[5:4] == ATOP_LOAD);
  // Swap and compare are not supported and end in SLVERR
  assign wr_fail  = wr_out_of_range | ~(is_plain | is_add);
  assign old_word = mem_q[wr_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_pending_q <= 1'b0;
      r_pending_q <= 1'b0;
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (b_valid_o && b_ready_i) begin
        b_pending_q <= 1'b0;
      end
      if (r_valid_o && r_ready_i) begin
        r_pending_q <= 1'b0;
      end
      if (wr_accept) begin
        b_pending_q <= 1'b1;
        r_pending_q <= aw_atop_i[ATOP_R_RESP];
        if (!wr_fail) begin
          mem_q[wr_idx] <= is_add ? old_word + w_data_i : w_data_i;
        end
      end else if (rd_accept) begin
        r_pending_q <= 1'b1;
      end
    end
  end

  // Response payload, captured at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      b_resp_q <= wr_fail ? RESP_SLVERR : RESP_OKAY;
      r_resp_q <= wr_fail ? RESP_SLVERR : RESP_OKAY;
      r_data_q <= wr_fail ? '0 : old_word;
    end else if (rd_accept) begin
      r_resp_q <= rd_out_of_range ? RESP_SLVERR : RESP_OKAY;
      r_data_q <= rd_out_of_range ? '0 : mem_q[rd_idx];
    end
  end

  assign b_valid_o = b_pending_q;
  assign b_resp_o  = b_resp_q;
  assign r_valid_o = r_pending_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;
  // Single-beat reads only
  assign r_last_o  = 1'b1;

endmodule

/* verilog/serializer_top.sv */
`timescale 1ns/1ns

module serializer_top #(
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                s_aw_valid_i,
  output logic                s_aw_ready_o,
  input  axi_chan_pkg::id_t   s_aw_id_i,
  input  axi_chan_pkg::addr_t s_aw_addr_i,
  input  axi_chan_pkg::atop_t s_aw_atop_i,
  input  logic                s_w_valid_i,
  output logic                s_w_ready_o,
  input  axi_chan_pkg::data_t s_w_data_i,
  output logic                s_b_valid_o,
  input  logic                s_b_ready_i,
  output axi_chan_pkg::id_t   s_b_id_o,
  output axi_chan_pkg::resp_t s_b_resp_o,
  input  logic                s_ar_valid_i,
  output logic                s_ar_ready_o,
  input  axi_chan_pkg::id_t   s_ar_id_i,
  input  axi_chan_pkg::addr_t s_ar_addr_i,
  output logic                s_r_valid_o,
  input  logic                s_r_ready_i,
  output axi_chan_pkg::id_t   s_r_id_o,
  output axi_chan_pkg::data_t s_r_data_o,
  output axi_chan_pkg::resp_t s_r_resp_o,
  output logic                s_r_last_o
);

  // Handshakes between serializer and target
  logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready;
  logic m_b_valid, m_b_ready, m_ar_valid, m_ar_ready;
  logic m_r_valid, m_r_ready, r_last;

  assign s_r_last_o = r_last;

  axi_serializer #(
    .MaxReadTxns  ( MaxReadTxns  ),
    .MaxWriteTxns ( MaxWriteTxns )
  ) serializer (
    .clk_i                  ( clk_i        ),
    .reset_i                ( reset_i      ),
    .s_aw_valid_i           ( s_aw_valid_i ),
    .s_aw_ready_o           ( s_aw_ready_o ),
    .s_aw_id_i              ( s_aw_id_i    ),
    .s_aw_atop_i            ( s_aw_atop_i  ),
    .s_w_valid_i            ( s_w_valid_i  ),
    .s_w_ready_o            ( s_w_ready_o  ),
    .s_b_valid_o            ( s_b_valid_o  ),
    .s_b_ready_i            ( s_b_ready_i  ),
    .s_b_id_o               ( s_b_id_o     ),
    .s_ar_valid_i           ( s_ar_valid_i ),
    .s_ar_ready_o           ( s_ar_ready_o ),
    .s_ar_id_i              ( s_ar_id_i    ),
    .s_r_valid_o            ( s_r_valid_o  ),
    .s_r_ready_i            ( s_r_ready_i  ),
    .s_r_last_i_from_target ( r_last       ),
    .s_r_id_o               ( s_r_id_o     ),
    .m_aw_valid_o           ( m_aw_valid   ),
    .m_aw_ready_i           ( m_aw_ready   ),
    // The target sees only ID zero and has no ID ports
    .m_aw_id_o              (              ),
    .m_w_valid_o            ( m_w_valid    ),
    .m_w_ready_i            ( m_w_ready    ),
    .m_b_valid_i            ( m_b_valid    ),
    .m_b_ready_o            ( m_b_ready    ),
    .m_ar_valid_o           ( m_ar_valid   ),
    .m_ar_ready_i           ( m_ar_ready   ),
    .m_ar_id_o              (              ),
    .m_r_valid_i            ( m_r_valid    ),
    .m_r_ready_o            ( m_r_ready    ),
    .m_r_last_i             ( r_last       )
  );

  // Payload goes straight to and from the target
  mem_target target (
    .clk_i      ( clk_i       ),
    .reset_i    ( reset_i     ),
    .aw_valid_i ( m_aw_valid  ),
    .aw_ready_o ( m_aw_ready  ),
    .aw_addr_i  ( s_aw_addr_i ),
    .aw_atop_i  ( s_aw_atop_i ),
    .w_valid_i  ( m_w_valid   ),
    .w_ready_o  ( m_w_ready   ),
    .w_data_i   ( s_w_data_i  ),
    .b_valid_o  ( m_b_valid   ),
    .b_ready_i  ( m_b_ready   ),
    .b_resp_o   ( s_b_resp_o  ),
    .ar_valid_i ( m_ar_valid  ),
    .ar_ready_o ( m_ar_ready  ),
    .ar_addr_i  ( s_ar_addr_i ),
    .r_valid_o  ( m_r_valid   ),
    .r_ready_i  ( m_r_ready   ),
    .r_data_o   ( s_r_data_o  ),
    .r_resp_o   ( s_r_resp_o  ),
    .r_last_o   ( r_last      )
  );

endmodule

/* bench/serializer_props.sv */
`timescale 1ns/1ns

module serializer_props (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        s_aw_valid_i,
  input logic                        s_aw_ready_i,
  input logic                        m_aw_valid_i,
  input logic                        m_aw_ready_i,
  input logic                        s_ar_valid_i,
  input logic                        s_ar_ready_i,
  input logic                        m_ar_valid_i,
  input logic                        m_ar_ready_i,
  input logic                        s_b_valid_i,
  input logic                        s_b_ready_i,
  input logic                        m_b_valid_i,
  input logic                        m_b_ready_i,
  input logic                        s_r_valid_i,
  input logic                        s_r_ready_i,
  input logic                        m_r_valid_i,
  input logic                        m_r_ready_i,
  input axi_chan_pkg::id_t           m_aw_id_i,
  input axi_chan_pkg::id_t           m_ar_id_i,
  input serializer_pkg::atop_state_e state_i
);
  import serializer_pkg::*;

  // Requests accepted upstream reach the target in the same cycle
  aw_kept: assert property (@(posedge clk_i) disable iff (reset_i)
    s_aw_valid_i && s_aw_ready_i |-> m_aw_valid_i && m_aw_ready_i)
    else $error("AW beat accepted upstream but not forwarded to the target");

  ar_kept: assert property (@(posedge clk_i) disable iff (reset_i)
    s_ar_valid_i && s_ar_ready_i |-> m_ar_valid_i && m_ar_ready_i)
    else $error("AR beat accepted upstream but not forwarded to the target");

  // Responses taken from the target reach the manager
  b_kept: assert property (@(posedge clk_i) disable iff (reset_i)
    m_b_valid_i && m_b_ready_i |-> s_b_valid_i && s_b_ready_i)
    else $error("B beat taken from the target but not passed upstream");

  r_kept: assert property (@(posedge clk_i) disable iff (reset_i)
    m_r_valid_i && m_r_ready_i |-> s_r_valid_i && s_r_ready_i)
    else $error("R beat taken from the target but not passed upstream");

  // The atomic runs alone
  atop_alone: assert property (@(posedge clk_i) disable iff (reset_i)
    state_i == ATOP_EXECUTE |-> !m_aw_valid_i && !m_ar_valid_i)
    else $error("Address beat forwarded while an atomic is executing");

  ids_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    m_aw_id_i == '0 && m_ar_id_i == '0)
    else $error("Downstream ID is not zero");

endmodule

bind axi_serializer serializer_props props (
  .clk_i        ( clk_i        ),
  .reset_i      ( reset_i      ),
  .s_aw_valid_i ( s_aw_valid_i ),
  .s_aw_ready_i ( s_aw_ready_o ),
  .m_aw_valid_i ( m_aw_valid_o ),
  .m_aw_ready_i ( m_aw_ready_i ),
  .s_ar_valid_i ( s_ar_valid_i ),
  .s_ar_ready_i ( s_ar_ready_o ),
  .m_ar_valid_i ( m_ar_valid_o ),
  .m_ar_ready_i ( m_ar_ready_i ),
  .s_b_valid_i  ( s_b_valid_o  ),
  .s_b_ready_i  ( s_b_ready_i  ),
  .m_b_valid_i  ( m_b_valid_i  ),
  .m_b_ready_i  ( m_b_ready_o  ),
  .s_r_valid_i  ( s_r_valid_o  ),
  .s_r_ready_i  ( s_r_ready_i  ),
  .m_r_valid_i  ( m_r_valid_i  ),
  .m_r_ready_i  ( m_r_ready_o  ),
  .m_aw_id_i    ( m_aw_id_o    ),
  .m_ar_id_i    ( m_ar_id_o    ),
  .state_i      ( state_q      )
);

/* bench/serializer_tb.sv */
`timescale 1ns/1ns

module serializer_tb;
  import axi_chan_pkg::*;

  localparam int unsigned Timeout  = 50;
  localparam int unsigned MemWords = 16;
  // Add operation with the atomic type in bits 5:4
  localparam atop_t AtopPlain    = 6'b000000;
  localparam atop_t AtopStoreAdd = {ATOP_STORE, 4'b0000};
  localparam atop_t AtopLoadAdd  = {ATOP_LOAD, 4'b0000};

  logic  clk = 1'b0;
  logic  reset;
  logic  s_aw_valid, s_aw_ready;
  id_t   s_aw_id;
  addr_t s_aw_addr;
  atop_t s_aw_atop;
  logic  s_w_valid, s_w_ready;
  data_t s_w_data;
  logic  s_b_valid, s_b_ready;
  id_t   s_b_id;
  resp_t s_b_resp;
  logic  s_ar_valid, s_ar_ready;
  id_t   s_ar_id;
  addr_t s_ar_addr;
  logic  s_r_valid, s_r_ready;
  id_t   s_r_id;
  data_t s_r_data;
  resp_t s_r_resp;
  logic  s_r_last;

  // Expected memory contents
  data_t model_mem [MemWords];
  int    checks;
  int    errors;

  always #2 clk = ~clk;

  serializer_top #(
    .MaxReadTxns  ( 4 ),
    .MaxWriteTxns ( 4 )
  ) UUT (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .s_aw_valid_i ( s_aw_valid ),
    .s_aw_ready_o ( s_aw_ready ),
    .s_aw_id_i    ( s_aw_id    ),
    .s_aw_addr_i  ( s_aw_addr  ),
    .s_aw_atop_i  ( s_aw_atop  ),
    .s_w_valid_i  ( s_w_valid  ),
    .s_w_ready_o  ( s_w_ready  ),
    .s_w_data_i   ( s_w_data   ),
    .s_b_valid_o  ( s_b_valid  ),
    .s_b_ready_i  ( s_b_ready  ),
    .s_b_id_o     ( s_b_id     ),
    .s_b_resp_o   ( s_b_resp   ),
    .s_ar_valid_i ( s_ar_valid ),
    .s_ar_ready_o ( s_ar_ready ),
    .s_ar_id_i    ( s_ar_id    ),
    .s_ar_addr_i  ( s_ar_addr  ),
    .s_r_valid_o  ( s_r_valid  ),
    .s_r_ready_i  ( s_r_ready  ),
    .s_r_id_o     ( s_r_id     ),
    .s_r_data_o   ( s_r_data   ),
    .s_r_resp_o   ( s_r_resp   ),
    .s_r_last_o   ( s_r_last   )
  );

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Check failed: %s", what);
    end
  endtask

  // Returns at the clock edge on which AW and W transfer
  task automatic issue_write(input id_t id, input addr_t addr, input data_t data,
                             input atop_t atop);
    int cycles;
    @(posedge clk);
    s_aw_valid <= 1'b1;
    s_aw_id    <= id;
    s_aw_addr  <= addr;
    s_aw_atop  <= atop;
    s_w_valid  <= 1'b1;
    s_w_data   <= data;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!(s_aw_ready && s_w_ready) && cycles < Timeout);
    if (!(s_aw_ready && s_w_ready)) begin
      stop_on_timeout("AW and W ready");
    end
    @(posedge clk);
    s_aw_valid <= 1'b0;
    s_w_valid  <= 1'b0;
  endtask

  task automatic issue_read(input id_t id, input addr_t addr);
    int cycles;
    @(posedge clk);
    s_ar_valid <= 1'b1;
    s_ar_id    <= id;
    s_ar_addr  <= addr;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!s_ar_ready && cycles < Timeout);
    if (!s_ar_ready) begin
      stop_on_timeout("AR ready");
    end
    @(posedge clk);
    s_ar_valid <= 1'b0;
  endtask

  // Latency counts cycles from the call to the response transfer
  task automatic take_b(output id_t id, output resp_t resp, output int latency);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!(s_b_valid && s_b_ready) && cycles < Timeout);
    if (!(s_b_valid && s_b_ready)) begin
      stop_on_timeout("a B response");
    end
    id      = s_b_id;
    resp    = s_b_resp;
    latency = cycles;
    @(posedge clk);
  endtask

  task automatic take_r(output id_t id, output data_t data, output resp_t resp,
                        output int latency);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!(s_r_valid && s_r_ready) && cycles < Timeout);
    if (!(s_r_valid && s_r_ready)) begin
      stop_on_timeout("an R response");
    end
    id      = s_r_id;
    data    = s_r_data;
    resp    = s_r_resp;
    latency = cycles;
    check_equal("s_r_last", s_r_last, 1'b1);
    @(posedge clk);
  endtask

  task automatic write_and_check(input id_t id, input addr_t addr, input data_t data,
                                 input atop_t atop, input resp_t exp_resp);
    id_t   got_id;
    resp_t got_resp;
    int    latency;
    issue_write(id, addr, data, atop);
    take_b(got_id, got_resp, latency);
    check_equal("s_b_id", got_id, id);
    check_equal("s_b_resp", got_resp, exp_resp);
    check_equal("s_b_valid latency", latency, 1);
  endtask

  task automatic read_and_check(input id_t id, input addr_t addr, input data_t exp_data,
                                input resp_t exp_resp);
    id_t   got_id;
    data_t got_data;
    resp_t got_resp;
    int    latency;
    issue_read(id, addr);
    take_r(got_id, got_data, got_resp, latency);
    check_equal("s_r_id", got_id, id);
    check_equal("s_r_data", got_data, exp_data);
    check_equal("s_r_resp", got_resp, exp_resp);
    check_equal("s_r_valid latency", latency, 1);
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_equal("s_b_valid", s_b_valid, 1'b0);
    check_equal("s_r_valid", s_r_valid, 1'b0);
    for (int i = 0; i < MemWords; i++) begin
      read_and_check(id_t'($urandom), addr_t'(i * 4), '0, RESP_OKAY);
    end
  endtask

  // Word 1 is read back again by the ordering test
  task automatic test_write_read();
    addr_t addr;
    data_t data;
    addr = 8'h04;
    data = $urandom;
    write_and_check(id_t'($urandom), addr, data, AtopPlain, RESP_OKAY);
    model_mem[addr[5:2]] = data;
    read_and_check(id_t'($urandom), addr, data, RESP_OKAY);
  endtask

  // Reads queue up behind a stalled R channel and return in order
  task automatic test_read_order();
    id_t base;
    base = id_t'($urandom);
    @(posedge clk);
    s_r_ready <= 1'b0;
    fork
      begin
        for (int k = 0; k < 3; k++) begin
          issue_read(id_t'(base + k), addr_t'(k * 4));
        end
      end
      begin
        id_t   got_id;
        data_t got_data;
        resp_t got_resp;
        int    latency;
        repeat (6) @(posedge clk);
        s_r_ready <= 1'b1;
        for (int k = 0; k < 3; k++) begin
          take_r(got_id, got_data, got_resp, latency);
          check_equal("s_r_id", got_id, id_t'(base + k));
          check_equal("s_r_data", got_data, model_mem[k]);
          check_equal("s_r_resp", got_resp, RESP_OKAY);
        end
      end
    join
  endtask

  task automatic test_store_add();
    addr_t addr;
    data_t x;
    data_t y;
    addr = 8'h30;
    x    = $urandom;
    y    = $urandom;
    write_and_check(id_t'($urandom), addr, x, AtopPlain, RESP_OKAY);
    write_and_check(id_t'($urandom), addr, y, AtopStoreAdd, RESP_OKAY);
    model_mem[addr[5:2]] = x + y;
    read_and_check(id_t'($urandom), addr, x + y, RESP_OKAY);
  endtask

  task automatic test_load_add();
    id_t   rid;
    id_t   aid;
    addr_t addr;
    data_t old_word;
    data_t operand;
    time   aw_time;
    time   r_time;
    rid      = id_t'($urandom);
    aid      = id_t'(rid + 1);
    addr     = 8'h24;
    old_word = model_mem[9];
    operand  = $urandom;
    @(posedge clk);
    s_r_ready <= 1'b0;
    issue_read(rid, 8'h08);
    fork
      begin
        issue_write(aid, addr, operand, AtopLoadAdd);
        aw_time = $time;
      end
      begin
        id_t   got_id;
        data_t got_data;
        resp_t got_resp;
        int    latency;
        repeat (5) begin
          @(negedge clk);
          check_true(!s_aw_ready, "load-add accepted while a read was outstanding");
        end
        @(posedge clk);
        s_r_ready <= 1'b1;
        take_r(got_id, got_data, got_resp, latency);
        r_time = $time;
        check_equal("s_r_id", got_id, rid);
        check_equal("s_r_data", got_data, model_mem[2]);
      end
    join
    check_true(aw_time > r_time, "load-add accepted before the earlier R beat");
    // The atomic answers on both channels at once
    fork
      begin
        id_t   got_id;
        resp_t got_resp;
        int    latency;
        take_b(got_id, got_resp, latency);
        check_equal("s_b_id", got_id, aid);
        check_equal("s_b_resp", got_resp, RESP_OKAY);
      end
      begin
        id_t   got_id;
        data_t got_data;
        resp_t got_resp;
        int    latency;
        take_r(got_id, got_data, got_resp, latency);
        check_equal("s_r_id", got_id, aid);
        check_equal("s_r_data", got_data, old_word);
        check_equal("s_r_resp", got_resp, RESP_OKAY);
      end
    join
    model_mem[9] = old_word + operand;
    read_and_check(id_t'($urandom), addr, old_word + operand, RESP_OKAY);
  endtask

  // Out of range address aliases onto a word that must stay unchanged
  task automatic test_bad_addr();
    addr_t addr;
    addr = 8'h44;
    write_and_check(id_t'($urandom), addr, $urandom, AtopPlain, RESP_SLVERR);
    read_and_check(id_t'($urandom), addr_t'(addr[5:2] * 4), model_mem[addr[5:2]],
                   RESP_OKAY);
  endtask

  initial begin
    void'($urandom(5));
    checks = 0;
    errors = 0;
    reset      <= 1'b1;
    s_aw_valid <= 1'b0;
    s_aw_id    <= '0;
    s_aw_addr  <= '0;
    s_aw_atop  <= '0;
    s_w_valid  <= 1'b0;
    s_w_data   <= '0;
    s_b_ready  <= 1'b1;
    s_ar_valid <= 1'b0;
    s_ar_id    <= '0;
    s_ar_addr  <= '0;
    s_r_ready  <= 1'b1;
    for (int i = 0; i < MemWords; i++) begin
      model_mem[i] = '0;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_write_read();
    test_read_order();
    test_store_add();
    test_load_add();
    test_bad_addr();
    finish_run();
  end

endmodule

/* axi_serializer.f */
verilog/axi_chan_pkg.sv
verilog/serializer_pkg.sv
verilog/id_fifo.sv
verilog/axi_serializer.sv
verilog/mem_target.sv
verilog/serializer_top.sv
bench/serializer_props.sv
bench/serializer_tb.sv

/* Bender.yml */
package:
  name: axi_serializer

sources:
  # Packages first, they are imported by every module below
  - verilog/axi_chan_pkg.sv
  - verilog/serializer_pkg.sv
  - verilog/id_fifo.sv
  - verilog/axi_serializer.sv
  - verilog/mem_target.sv
  - verilog/serializer_top.sv
  - target: test
    files:
      - bench/serializer_props.sv
      - bench/serializer_tb.sv
